// ==== project.f ====
rtl/core_demux_pkg.sv
rtl/addr_decoder.sv
rtl/request_router.sv
rtl/periph_txn_ctrl.sv
rtl/resp_mux.sv
rtl/core_demux.sv
tb/tb_core_demux.sv

// ==== rtl/addr_decoder.sv ====
// Address decoder that remaps the top nibble and picks the target of a core request

`timescale 1ns/100ps

module addr_decoder
#(
   parameter bit                      remap_en   = 1'b1,
   parameter bit                      alias_en   = 1'b1,
   parameter core_demux_pkg::region_t alias_base = 12'h000
)
(
   input  logic [9:0]                base_addr_i,
   input  core_demux_pkg::core_req_t core_req_i,
   output core_demux_pkg::core_req_t req_o,
   output core_demux_pkg::target_e   target_o
);

   import core_demux_pkg::*;

   // Alias regions next to the alias base
   localparam region_t alias_sh_hi = region_t'(alias_base + 12'd1);
   localparam region_t alias_per   = region_t'(alias_base + 12'd2);

   logic [3:0] nibble_in;
   logic [3:0] nibble_out;
   addr_t      addr_remap;
   region_t    region;
   region_t    tcdm_rw;
   region_t    tcdm_ts;
   region_t    dem_per;
   logic       direct_link;
   logic       is_sh;
   logic       is_per;

   // ************************************************************
   // Address remap
   // ************************************************************
   assign nibble_in = core_req_i.addr[addr_w-1 -: 4];

   // Swap own cluster nibble with 1 and back
   always_comb
   begin
      nibble_out = nibble_in;
      if (remap_en)
      begin
         if (nibble_in == base_addr_i[9:6])
            nibble_out = 4'h1;
         else if (nibble_in == 4'h1)
            nibble_out = base_addr_i[9:6];
      end
   end

   assign addr_remap = {nibble_out, core_req_i.addr[addr_w-5:0]};

   always_comb
   begin
      req_o      = core_req_i;                        // Payload unchanged
      req_o.addr = addr_remap;
   end

   // ************************************************************
   // Region decode
   // ************************************************************
   assign region  = addr_remap[addr_w-1 -: region_w];
   assign tcdm_rw = {base_addr_i, 2'b00};
   assign tcdm_ts = {base_addr_i, 2'b01};
   assign dem_per = {base_addr_i, 2'b10};

   // Demux peripherals live at offsets 0x4000..0x7FFF
   assign direct_link = (addr_remap[19:16] == 4'h0) && (addr_remap[15:14] == 2'b01);

   assign is_sh  = (region == tcdm_rw) || (region == tcdm_ts)
                   || (alias_en && ((region == alias_base) || (region == alias_sh_hi)));
   assign is_per = (region == dem_per) || (alias_en && (region == alias_per));

   always_comb
   begin
      if (is_sh)
         target_o = target_sh;
      else if (is_per && direct_link)
         target_o = target_ext;
      else
         target_o = target_pe;                        // Rest of the memory map
   end

endmodule

// ==== rtl/core_demux.sv ====
// Core data-port demux top joining decoder, router, peripheral controller and response mux

`timescale 1ns/100ps

module core_demux
#(
   parameter bit                      remap_en   = 1'b1,
   parameter bit                      alias_en   = 1'b1,
   parameter core_demux_pkg::region_t alias_base = 12'h000
)
(
   input  logic                      clk,
   input  logic                      rst_ni,
   input  logic [9:0]                base_addr_i,

   // Core side
   input  logic                      core_req_i,
   input  core_demux_pkg::core_req_t core_req_data_i,
   output logic                      core_gnt_o,
   output core_demux_pkg::core_rsp_t core_rsp_o,

   // Shared TCDM
   output logic                      sh_req_o,
   output core_demux_pkg::core_req_t sh_data_o,
   input  logic                      sh_gnt_i,
   input  core_demux_pkg::core_rsp_t sh_rsp_i,

   // Demux peripherals
   output logic                      ext_req_o,
   output core_demux_pkg::core_req_t ext_data_o,
   input  logic                      ext_gnt_i,
   input  core_demux_pkg::core_rsp_t ext_rsp_i,

   // Peripheral interconnect
   output logic                      pe_req_o,
   output core_demux_pkg::core_req_t pe_data_o,
   input  logic                      pe_gnt_i,
   input  core_demux_pkg::core_rsp_t pe_rsp_i,

   // L2 performance strobes
   output logic                      perf_l2_ld_o,
   output logic                      perf_l2_st_o,
   output logic                      perf_l2_ld_cyc_o,
   output logic                      perf_l2_st_cyc_o
);

   import core_demux_pkg::*;

   core_req_t req_remap;
   target_e   target;
   logic      pe_req;
   logic      pe_gnt;
   core_rsp_t pe_rsp;

   assign sh_data_o  = req_remap;                     // Same payload to every target
   assign ext_data_o = req_remap;
   assign pe_data_o  = req_remap;

   addr_decoder #(
      .remap_en   (remap_en),
      .alias_en   (alias_en),
      .alias_base (alias_base)
   ) addr_decoder_i (
      .base_addr_i (base_addr_i),
      .core_req_i  (core_req_data_i),
      .req_o       (req_remap),
      .target_o    (target)
   );

   request_router request_router_i (
      .req_i            (core_req_i),
      .target_i         (target),
      .we_n_i           (req_remap.we_n),
      .sh_req_o         (sh_req_o),
      .ext_req_o        (ext_req_o),
      .pe_req_o         (pe_req),
      .sh_gnt_i         (sh_gnt_i),
      .ext_gnt_i        (ext_gnt_i),
      .pe_gnt_i         (pe_gnt),
      .gnt_o            (core_gnt_o),
      .perf_l2_ld_o     (perf_l2_ld_o),
      .perf_l2_st_o     (perf_l2_st_o),
      .perf_l2_ld_cyc_o (perf_l2_ld_cyc_o),
      .perf_l2_st_cyc_o (perf_l2_st_cyc_o)
   );

   periph_txn_ctrl periph_txn_ctrl_i (
      .clk      (clk),
      .rst_ni   (rst_ni),
      .req_i    (pe_req),
      .gnt_o    (pe_gnt),
      .pe_req_o (pe_req_o),
      .pe_gnt_i (pe_gnt_i),
      .pe_rsp_i (pe_rsp_i),
      .rsp_o    (pe_rsp)
   );

   resp_mux resp_mux_i (
      .clk       (clk),
      .rst_ni    (rst_ni),
      .req_i     (core_req_i),
      .target_i  (target),
      .sh_rsp_i  (sh_rsp_i),
      .pe_rsp_i  (pe_rsp),
      .ext_rsp_i (ext_rsp_i),
      .rsp_o     (core_rsp_o)
   );

endmodule

// ==== rtl/core_demux_pkg.sv ====
// Core data-port demux package with shared widths, target encoding and request/response types

package core_demux_pkg;

   // ************************************************************
   // Widths
   // ************************************************************
   localparam int unsigned addr_w   = 32;
   localparam int unsigned data_w   = 32;
   localparam int unsigned be_w     = data_w / 8;
   localparam int unsigned region_w = 12;            // Address bits 31..20

   typedef logic [addr_w-1:0]   addr_t;
   typedef logic [data_w-1:0]   data_t;
   typedef logic [region_w-1:0] region_t;

   // ************************************************************
   // Targets
   // ************************************************************
   // Shared TCDM, peripheral interconnect, demux peripherals
   typedef enum logic [1:0]
   {
      target_sh,
      target_pe,
      target_ext
   } target_e;

   // ************************************************************
   // Request and response payloads
   // ************************************************************
   // Held steady by the requester until gnt
   typedef struct packed
   {
      addr_t           addr;
      logic            we_n;                          // Low means store
      data_t           wdata;
      logic [be_w-1:0] be;
   } core_req_t;

   // Single-cycle valid pulse, no back-pressure
   typedef struct packed
   {
      logic  valid;
      data_t rdata;
      logic  opc;                                     // Error flag
   } core_rsp_t;

endpackage

// ==== rtl/periph_txn_ctrl.sv ====
// Peripheral interconnect controller with one transaction in flight and a two-stage response

`timescale 1ns/100ps

module periph_txn_ctrl
(
   input  logic                      clk,
   input  logic                      rst_ni,

   input  logic                      req_i,
   output logic                      gnt_o,

   output logic                      pe_req_o,
   input  logic                      pe_gnt_i,
   input  core_demux_pkg::core_rsp_t pe_rsp_i,

   output core_demux_pkg::core_rsp_t rsp_o
);

   import core_demux_pkg::*;

   typedef enum logic [1:0]
   {
      st_idle,
      st_pending,
      st_granted
   } state_e;

   state_e state_q;
   state_e state_d;

   logic   valid0_q;
   data_t  rdata0_q;
   logic   opc0_q;
   logic   valid1_q;
   data_t  rdata1_q;
   logic   opc1_q;

   // ************************************************************
   // Transaction FSM
   // ************************************************************
   always_ff @(posedge clk or negedge rst_ni)
   begin
      if (!rst_ni)
         state_q <= st_idle;
      else
         state_q <= state_d;
   end

   always_comb
   begin
      state_d  = state_q;
      pe_req_o = 1'b0;
      gnt_o    = 1'b0;
      case (state_q)
         st_idle:
         begin
            pe_req_o = req_i;
            if (req_i && pe_gnt_i)
               state_d = st_pending;
         end
         st_pending:
         begin
            if (pe_rsp_i.valid)                       // Wait for the PE answer
               state_d = st_granted;
         end
         st_granted:
         begin
            gnt_o   = 1'b1;                           // Core sees its grant now
            state_d = st_idle;
         end
         default:
         begin
            state_d = st_idle;
         end
      endcase
   end

   // ************************************************************
   // Response pipeline
   // ************************************************************
   always_ff @(posedge clk or negedge rst_ni)
   begin
      if (!rst_ni)
      begin
         valid0_q <= 1'b0;
         valid1_q <= 1'b0;
      end
      else
      begin
         valid0_q <= pe_rsp_i.valid;
         valid1_q <= valid0_q;
      end
   end

   always_ff @(posedge clk)
   begin
      if (pe_rsp_i.valid)
      begin
         rdata0_q <= pe_rsp_i.rdata;
         opc0_q   <= pe_rsp_i.opc;
      end
      if (valid0_q)
      begin
         rdata1_q <= rdata0_q;
         opc1_q   <= opc0_q;
      end
   end

   assign rsp_o = '{valid: valid1_q, rdata: rdata1_q, opc: opc1_q};

   // PE must not answer a request it never got
   assert property (@(posedge clk) disable iff (!rst_ni)
                    (state_q == st_idle) |-> !pe_rsp_i.valid)
      else $error("PE r_valid while no transaction pending");

endmodule

// ==== rtl/request_router.sv ====
// Request router that steers req/gnt to the decoded target and makes L2 perf strobes

`timescale 1ns/100ps

module request_router
(
   input  logic                    req_i,
   input  core_demux_pkg::target_e target_i,
   input  logic                    we_n_i,

   output logic                    sh_req_o,
   output logic                    ext_req_o,
   output logic                    pe_req_o,
   input  logic                    sh_gnt_i,
   input  logic                    ext_gnt_i,
   input  logic                    pe_gnt_i,
   output logic                    gnt_o,

   output logic                    perf_l2_ld_o,
   output logic                    perf_l2_st_o,
   output logic                    perf_l2_ld_cyc_o,
   output logic                    perf_l2_st_cyc_o
);

   import core_demux_pkg::*;

   logic l2_req;

   // ************************************************************
   // Request and grant steering
   // ************************************************************
   assign sh_req_o  = req_i && (target_i == target_sh);
   assign ext_req_o = req_i && (target_i == target_ext);
   assign pe_req_o  = req_i && (target_i == target_pe);

   always_comb
   begin
      case (target_i)
         target_sh:  gnt_o = sh_gnt_i;
         target_ext: gnt_o = ext_gnt_i;
         target_pe:  gnt_o = pe_gnt_i;
         default:    gnt_o = 1'b0;
      endcase
   end

   // ************************************************************
   // L2 performance strobes
   // ************************************************************
   assign l2_req = req_i && (target_i != target_sh);  // Anything outside the TCDM

   assign perf_l2_ld_cyc_o = l2_req & we_n_i;
   assign perf_l2_st_cyc_o = l2_req & ~we_n_i;
   assign perf_l2_ld_o     = perf_l2_ld_cyc_o & gnt_o;
   assign perf_l2_st_o     = perf_l2_st_cyc_o & gnt_o;

   // A core request reaches exactly one target
   always_comb
   begin
      assert final (!req_i || $onehot({sh_req_o, ext_req_o, pe_req_o}))
         else $error("core request not steered to exactly one target");
   end

endmodule

// ==== rtl/resp_mux.sv ====
// Response mux that tracks the target of the last request and returns its response

`timescale 1ns/100ps

module resp_mux
(
   input  logic                      clk,
   input  logic                      rst_ni,

   input  logic                      req_i,
   input  core_demux_pkg::target_e   target_i,

   input  core_demux_pkg::core_rsp_t sh_rsp_i,
   input  core_demux_pkg::core_rsp_t pe_rsp_i,
   input  core_demux_pkg::core_rsp_t ext_rsp_i,

   output core_demux_pkg::core_rsp_t rsp_o
);

   import core_demux_pkg::*;

   target_e target_q;

   // ************************************************************
   // Response source tracking
   // ************************************************************
   // Updated on every request cycle, granted or not
   always_ff @(posedge clk or negedge rst_ni)
   begin
      if (!rst_ni)
         target_q <= target_sh;
      else if (req_i)
         target_q <= target_i;
   end

   // ************************************************************
   // Response select
   // ************************************************************
   always_comb
   begin
      case (target_q)
         target_sh:
         begin
            rsp_o     = sh_rsp_i;
            rsp_o.opc = 1'b0;                         // TCDM never reports errors
         end
         target_pe:
         begin
            rsp_o = pe_rsp_i;
         end
         target_ext:
         begin
            rsp_o = ext_rsp_i;
         end
         default:
         begin
            rsp_o = '0;
         end
      endcase
   end

endmodule

// ==== tb/tb_core_demux.sv ====
// Directed testbench for the core data-port demux with SH, EXT and PE target models

`timescale 1ns/100ps

module tb_core_demux;

   import core_demux_pkg::*;

   localparam int         timeout_cyc = 40;
   localparam logic [9:0] base_addr   = 10'h100;      // Own TCDM at 0x4000_0000
   localparam data_t      sh_key      = 32'h5a5a_0000;
   localparam data_t      ext_key     = 32'h00e0_e0e0;
   localparam data_t      pe_key      = 32'h3c00_00c3;

   logic        clk = 1'b0;
   logic        rst_ni;
   logic        core_req;
   core_req_t   core_data;
   logic        core_gnt;
   core_rsp_t   core_rsp;
   logic        sh_req;
   core_req_t   sh_data;
   logic        sh_gnt;
   core_rsp_t   sh_rsp = '0;
   logic        ext_req;
   core_req_t   ext_data;
   logic        ext_gnt;
   core_rsp_t   ext_rsp = '0;
   logic        pe_req;
   core_req_t   pe_data;
   logic        pe_gnt = 1'b0;
   core_rsp_t   pe_rsp = '0;
   logic        perf_ld;
   logic        perf_st;
   logic        perf_ld_cyc;
   logic        perf_st_cyc;

   // Target model state, sampled mid-cycle
   logic        sh_fire     = 1'b0;
   logic        ext_fire    = 1'b0;
   logic        pe_fire     = 1'b0;
   logic        pe_req_seen = 1'b0;
   addr_t       sh_addr_s   = '0;
   addr_t       ext_addr_s  = '0;
   addr_t       pe_addr_s   = '0;
   int          pe_wait     = 0;

   logic [31:0] lfsr_state  = 32'h44e3dca4;
   int          err_cnt      = 0;
   int          tests_run    = 0;
   int          tests_failed = 0;

   always #10 clk = ~clk;

   core_demux core_demux_i (
      .clk              (clk),
      .rst_ni           (rst_ni),
      .base_addr_i      (base_addr),
      .core_req_i       (core_req),
      .core_req_data_i  (core_data),
      .core_gnt_o       (core_gnt),
      .core_rsp_o       (core_rsp),
      .sh_req_o         (sh_req),
      .sh_data_o        (sh_data),
      .sh_gnt_i         (sh_gnt),
      .sh_rsp_i         (sh_rsp),
      .ext_req_o        (ext_req),
      .ext_data_o       (ext_data),
      .ext_gnt_i        (ext_gnt),
      .ext_rsp_i        (ext_rsp),
      .pe_req_o         (pe_req),
      .pe_data_o        (pe_data),
      .pe_gnt_i         (pe_gnt),
      .pe_rsp_i         (pe_rsp),
      .perf_l2_ld_o     (perf_ld),
      .perf_l2_st_o     (perf_st),
      .perf_l2_ld_cyc_o (perf_ld_cyc),
      .perf_l2_st_cyc_o (perf_st_cyc)
   );

   // ************************************************************
   // Target models
   // ************************************************************
   always @(negedge clk)
   begin
      sh_fire     = sh_req && sh_gnt;
      ext_fire    = ext_req && ext_gnt;
      pe_fire     = pe_req && pe_gnt;
      pe_req_seen = pe_req;
      sh_addr_s   = sh_data.addr;
      ext_addr_s  = ext_data.addr;
      if (pe_fire)
         pe_addr_s = pe_data.addr;                   // Held until the PE answers
   end

   always @(posedge clk)
   begin
      #2;
      sh_rsp  = '{valid: sh_fire, rdata: sh_addr_s ^ sh_key, opc: sh_addr_s[2]};
      ext_rsp = '{valid: ext_fire, rdata: ext_addr_s ^ ext_key, opc: ext_addr_s[2]};
      pe_gnt  = pe_req_seen && !pe_gnt;              // One cycle after req, single pulse
      pe_rsp  = '0;
      if (pe_wait != 0)
      begin
         pe_wait = pe_wait - 1;
         if (pe_wait == 0)
            pe_rsp = '{valid: 1'b1, rdata: pe_addr_s ^ pe_key, opc: pe_addr_s[2]};
      end
      if (pe_fire)
         pe_wait = 2;                                // r_valid three cycles after transfer
   end

   // ************************************************************
   // Helpers and reference model
   // ************************************************************
   // Galois LFSR, one step per bit
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] val;
      val = '0;
      for (int i = 0; i < n; i++)
      begin
         val        = {val[30:0], lfsr_state[0]};
         lfsr_state = (lfsr_state >> 1) ^ (lfsr_state[0] ? 32'h8020_0003 : 32'h0);
      end
      return val;
   endfunction

   function automatic addr_t remap_addr(input addr_t a);
      logic [3:0] nib;
      nib = a[31:28];
      if (nib == base_addr[9:6])
         nib = 4'h1;
      else if (nib == 4'h1)
         nib = base_addr[9:6];
      return {nib, a[27:0]};
   endfunction

   // Expected target of an already remapped address
   function automatic target_e decode_target(input addr_t a);
      logic [11:0] r;
      logic        dem;
      r   = a[31:20];
      dem = (r == {base_addr, 2'b10}) || (r == 12'h002);
      if ((r == {base_addr, 2'b00}) || (r == {base_addr, 2'b01}) || (r == 12'h000)
          || (r == 12'h001))
         return target_sh;
      if (dem && (a[19:14] == 6'b000001))
         return target_ext;
      return target_pe;
   endfunction

   function automatic data_t key_of(input target_e t);
      case (t)
         target_sh:  return sh_key;
         target_ext: return ext_key;
         default:    return pe_key;
      endcase
   endfunction

   function automatic core_req_t port_data(input target_e t);
      case (t)
         target_sh:  return sh_data;
         target_ext: return ext_data;
         default:    return pe_data;
      endcase
   endfunction

   task automatic report_value(input string name, input logic [68:0] got,
                               input logic [68:0] exp);
      $display("FAILED %s: expected 0x%0h, got 0x%0h", name, exp, got);
      err_cnt++;
   endtask

   task automatic report_error(input string what);
      $display("ERROR: %s", what);
      err_cnt++;
   endtask

   task automatic end_test(input string name, input int errs_before);
      tests_run++;
      if (err_cnt == errs_before)
         $display("Test %s: ok", name);
      else
      begin
         tests_failed++;
         $display("Test %s: %0d check(s) failed", name, err_cnt - errs_before);
      end
   endtask

   // One core access; hold keeps the SH or EXT grant low for that many cycles
   task automatic access(input addr_t addr, input logic we_n, input int hold);
      addr_t     exp_addr;
      target_e   tgt;
      core_req_t payload;
      core_req_t exp_data;
      core_rsp_t exp_rsp;
      logic      is_l2;
      logic      exp_gnt;
      logic      rv_prev;
      logic      pe_gnt_prev;
      logic      done;
      int        n;
      exp_addr      = remap_addr(addr);
      tgt           = decode_target(exp_addr);
      is_l2         = (tgt != target_sh);
      payload       = '{addr: addr, we_n: we_n, wdata: rand_bits(32), be: 4'(rand_bits(4))};
      exp_data      = payload;
      exp_data.addr = exp_addr;
      exp_rsp       = '{valid: 1'b1, rdata: exp_addr ^ key_of(tgt), opc: is_l2 & exp_addr[2]};
      rv_prev       = 1'b0;
      pe_gnt_prev   = 1'b0;
      done          = 1'b0;
      n             = 0;
      @(posedge clk);
      #2;
      core_req  = 1'b1;
      core_data = payload;
      if (hold > 0)
      begin
         sh_gnt  = (tgt != target_sh);
         ext_gnt = (tgt != target_ext);
      end
      while (!done && (n < timeout_cyc))
      begin
         @(negedge clk);
         exp_gnt = (tgt == target_pe) ? rv_prev : (n >= hold);
         if ((n == 0) && ({sh_req, ext_req, pe_req} !==
                          {tgt == target_sh, tgt == target_ext, tgt == target_pe}))
            report_value("{sh_req_o,ext_req_o,pe_req_o}", {sh_req, ext_req, pe_req},
                         {tgt == target_sh, tgt == target_ext, tgt == target_pe});
         if (port_data(tgt) !== exp_data)
            report_value("target data_o", port_data(tgt), exp_data);
         if (core_gnt !== exp_gnt)
            report_value("core_gnt_o", core_gnt, exp_gnt);
         if (perf_ld_cyc !== (is_l2 & we_n))
            report_value("perf_l2_ld_cyc_o", perf_ld_cyc, is_l2 & we_n);
         if (perf_st_cyc !== (is_l2 & ~we_n))
            report_value("perf_l2_st_cyc_o", perf_st_cyc, is_l2 & ~we_n);
         if (perf_ld !== (is_l2 & we_n & exp_gnt))
            report_value("perf_l2_ld_o", perf_ld, is_l2 & we_n & exp_gnt);
         if (perf_st !== (is_l2 & ~we_n & exp_gnt))
            report_value("perf_l2_st_o", perf_st, is_l2 & ~we_n & exp_gnt);
         if ((tgt == target_pe) && pe_gnt_prev && pe_req)
            report_error("pe_req_o still high in the cycle after the PE grant");
         rv_prev     = pe_rsp.valid;
         pe_gnt_prev = pe_gnt;
         done        = core_gnt;
         n++;
         @(posedge clk);
         #2;
         if (n == hold)
         begin
            sh_gnt  = 1'b1;
            ext_gnt = 1'b1;
         end
      end
      core_req = 1'b0;
      sh_gnt   = 1'b1;
      ext_gnt  = 1'b1;
      if (!done)
         report_error($sformatf("no core grant within %0d cycles for 0x%h", timeout_cyc, addr));
      else
      begin
         done = 1'b0;
         n    = 0;
         while (!done && (n < timeout_cyc))
         begin
            @(negedge clk);
            if (core_rsp.valid)
            begin
               done = 1'b1;
               if (n != 0)
                  report_error($sformatf("response came %0d cycles late", n));
               if (core_rsp.rdata !== exp_rsp.rdata)
                  report_value("core_rsp_o.rdata", core_rsp.rdata, exp_rsp.rdata);
               if (core_rsp.opc !== exp_rsp.opc)
                  report_value("core_rsp_o.opc", core_rsp.opc, exp_rsp.opc);
            end
            n++;
         end
         if (!done)
            report_error($sformatf("no core response for 0x%h", addr));
      end
   endtask

   // ************************************************************
   // Tests
   // ************************************************************
   task automatic remap_cases();
      int errs;
      errs = err_cnt;
      access({12'h100, 20'(rand_bits(20))}, 1'b1, 0);   // Lands in own TCDM
      if (sh_data.addr[31:28] !== 4'h4)
         report_value("sh_data_o.addr[31:28]", sh_data.addr[31:28], 4'h4);
      access({4'h4, 28'(rand_bits(28))}, 1'b1, 0);
      if (sh_data.addr[31:28] !== 4'h1)
         report_value("sh_data_o.addr[31:28]", sh_data.addr[31:28], 4'h1);
      access({4'h7, 28'(rand_bits(28))}, 1'b0, 0);      // Nibble passes unchanged
      if (sh_data.addr[31:28] !== 4'h7)
         report_value("sh_data_o.addr[31:28]", sh_data.addr[31:28], 4'h7);
      end_test("remap", errs);
   endtask

   task automatic decode_sweep();
      int          errs;
      logic [11:0] region;
      logic [19:0] offset;
      errs = err_cnt;
      for (int k = 0; k < 16; k++)
      begin
         offset = 20'(rand_bits(20));
         case (k % 8)
            0:       region = {base_addr, 2'b00};
            1:       region = {base_addr, 2'b01};
            2:       region = 12'h000;
            3:       region = 12'h001;
            4:       region = {base_addr, 2'b10};
            5:       region = {base_addr, 2'b10};
            6:       region = 12'h002;
            default: region = {4'h7, 8'(rand_bits(8))};
         endcase
         if ((k % 8 == 4) || (k % 8 == 6))
            offset[19:14] = 6'b000001;               // Direct link window
         if (k % 8 == 5)
            offset[19] = 1'b1;
         access(remap_addr({region, offset}), 1'(rand_bits(1)), 0);
      end
      end_test("decode", errs);
   endtask

   task automatic pe_timing();
      int errs;
      errs = err_cnt;
      access({12'h7c3, 20'(rand_bits(20)) & 20'hffffb}, 1'b1, 0);   // Even word
      access({12'h7c3, 20'(rand_bits(20)) | 20'h00004}, 1'b1, 0);   // Odd word, opc set
      access({12'h5e0, 20'(rand_bits(20))}, 1'b0, 0);
      end_test("pe_timing", errs);
   endtask

   task automatic backpressure();
      int errs;
      errs = err_cnt;
      for (int k = 0; k < 2; k++)
      begin
         access({12'h100, 20'(rand_bits(20))}, 1'b1, 1 + int'(rand_bits(3)));
         // Remaps into the demux peripheral window
         access({12'h102, 6'b000001, 14'(rand_bits(14))}, 1'b0, 1 + int'(rand_bits(3)));
      end
      end_test("backpressure", errs);
   endtask

   task automatic perf_strobes();
      int errs;
      errs = err_cnt;
      access({12'h6a1, 20'(rand_bits(20))}, 1'b1, 0);
      access({12'h6a1, 20'(rand_bits(20))}, 1'b0, 0);
      access({12'h102, 6'b000001, 14'(rand_bits(14))}, 1'b1, 0);
      access({12'h102, 6'b000001, 14'(rand_bits(14))}, 1'b0, 2);
      access({12'h101, 20'(rand_bits(20))}, 1'b1, 0);   // SH keeps strobes low
      access({12'h101, 20'(rand_bits(20))}, 1'b0, 0);
      end_test("perf", errs);
   endtask

   initial
   begin
      rst_ni    = 1'b0;
      core_req  = 1'b0;
      core_data = '0;
      sh_gnt    = 1'b1;
      ext_gnt   = 1'b1;
      repeat (4) @(posedge clk);
      #2;
      rst_ni = 1'b1;
      remap_cases();
      decode_sweep();
      pe_timing();
      backpressure();
      perf_strobes();
      $display("Tests run: %0d, tests failed: %0d, failed checks: %0d",
               tests_run, tests_failed, err_cnt);
      if (err_cnt == 0)
         $display("ALL TESTS PASSED");
      else
         $display("SOME TESTS FAILED");
      $finish;
   end

endmodule
